/* control_mapper.sv */
module control_mapper
	import pkwars_pkg::*;
(
	input  logic       btn_up,
	input  logic       btn_down,
	input  logic       btn_left,
	input  logic       btn_right,
	input  logic       btn_coin,
	input  logic       btn_start1,
	input  logic       btn_start2,
	input  logic       btn_fire1,
	input  logic       btn_fire2,      // alt key, no function in this game
	input  joy_t       joystick_0,
	input  joy_t       joystick_1,
	input  logic       status_rotate,
	input  logic       status_service,
	output ctrl_byte_t ctr1,
	output ctrl_byte_t ctr2
);

	logic m_left;
	logic m_right;
	logic m_fire;

	// key or either stick, rotated screen takes left/right from down/up
	always_comb begin
		if (status_rotate) begin
			m_left  = btn_down | joystick_0[JOY_DOWN] | joystick_1[JOY_DOWN];
			m_right = btn_up | joystick_0[JOY_UP] | joystick_1[JOY_UP];
		end else begin
			m_left  = btn_left | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
			m_right = btn_right | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
		end
	end

	assign m_fire = btn_fire1 | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];

	// both players share the same movement
	assign ctr1 = ~{1'b0, status_service, btn_start1, 2'b00, m_fire, m_right, m_left};

	// coin line is active high on the core side
	assign ctr2 = ~{~btn_coin, 1'b0, btn_start2, 2'b00, m_fire, m_right, m_left};

endmodule

/* core_reset_gen.sv */
module core_reset_gen (
	input  logic CLOCK_48,
	input  logic rst,
	input  logic ioctl_download,
	input  logic status_reset,   // osd reset entry
	input  logic menu_button,    // board button
	output logic core_reset,
	output logic rom_loaded
);

	logic download_d;
	logic download_done;

	// falling edge of the download
	assign download_done = download_d & ~ioctl_download;

	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			download_d <= ioctl_download;
			if (download_done)
				rom_loaded <= 1'b1; // sticky until rst
		end
	end

	// core stays in reset until a rom is in place
	always_ff @(posedge CLOCK_48) begin
		if (rst)
			core_reset <= 1'b1;
		else
			core_reset <= status_reset | menu_button | ~rom_loaded;
	end

	// the core never runs on a partly loaded rom
	reset_until_loaded: assert property (
		@(posedge CLOCK_48) disable iff (rst)
		!$past(rom_loaded) |-> core_reset
	);

endmodule

/* key_decoder.sv */
module key_decoder
	import pkwars_pkg::*;
(
	input  logic  CLOCK_48,
	input  logic  rst,
	input  logic  key_strobe,   // one cycle per ps/2 event
	input  logic  key_pressed,  // 1 make, 0 break
	input  byte_t key_code,
	output logic  btn_up,
	output logic  btn_down,
	output logic  btn_left,
	output logic  btn_right,
	output logic  btn_coin,
	output logic  btn_start1,
	output logic  btn_start2,
	output logic  btn_fire1,
	output logic  btn_fire2
);

	// one latch per key, make sets and break clears
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP:     btn_up     <= key_pressed;
				KEY_DOWN:   btn_down   <= key_pressed;
				KEY_LEFT:   btn_left   <= key_pressed;
				KEY_RIGHT:  btn_right  <= key_pressed;
				KEY_COIN:   btn_coin   <= key_pressed;
				KEY_START1: btn_start1 <= key_pressed;
				KEY_START2: btn_start2 <= key_pressed;
				KEY_FIRE1:  btn_fire1  <= key_pressed;
				KEY_FIRE2:  btn_fire2  <= key_pressed; // bomb on other boards
				default: ;                             // other keys ignored
			endcase
		end
	end

endmodule

/* pkwars_host.f */
pkwars_pkg.sv
rom_port_ctrl.sv
core_reset_gen.sv
key_decoder.sv
control_mapper.sv
pkwars_host.sv
pkwars_host_tb.sv

/* pkwars_host.sv */
module pkwars_host
	import pkwars_pkg::*;
#(
	parameter ioctl_addr_t GFX_BASE = GFX_BASE_DEFAULT
) (
	input  logic         CLOCK_48,
	input  logic         rst,
	output logic         led,

	// loader
	input  logic         ioctl_download,
	input  logic         ioctl_wr,
	input  ioctl_addr_t  ioctl_addr,
	input  byte_t        ioctl_dout,

	// sdram
	output logic         port_we,
	output logic         port1_req,
	output sdram_waddr_t port1_a,
	output logic [1:0]   port1_ds,
	output word16_t      port1_d,
	output logic         port2_req,
	output sdram_waddr_t port2_a,
	output logic [1:0]   port2_ds,
	output word16_t      port2_d,
	output sdram_raddr_t cpu1_addr,
	output sdram_raddr_t sp_addr,
	input  word16_t      cpu1_q,

	// game core
	input  cpu_addr_t    cpu_rom_addr,
	input  gfx_addr_t    gfx_rom_addr,
	output byte_t        cpu_rom_byte,
	output logic         core_reset,
	output ctrl_byte_t   ctr1,
	output ctrl_byte_t   ctr2,

	// firmware
	input  logic         status_reset,
	input  logic         status_rotate,
	input  logic         status_service,
	input  logic         menu_button,
	input  logic         key_strobe,
	input  logic         key_pressed,
	input  byte_t        key_code,
	input  joy_t         joystick_0,
	input  joy_t         joystick_1
);

	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;
	logic btn_fire1;
	logic btn_fire2;

	assign led = ~ioctl_download; // lit while idle

	rom_port_ctrl #(
		.GFX_BASE(GFX_BASE)
	) rom_port_ctrl_inst (
		.CLOCK_48(CLOCK_48),
		.rst(rst),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.cpu_rom_addr(cpu_rom_addr),
		.gfx_rom_addr(gfx_rom_addr),
		.cpu1_q(cpu1_q),
		.port_we(port_we),
		.port1_req(port1_req),
		.port1_a(port1_a),
		.port1_ds(port1_ds),
		.port1_d(port1_d),
		.port2_req(port2_req),
		.port2_a(port2_a),
		.port2_ds(port2_ds),
		.port2_d(port2_d),
		.cpu1_addr(cpu1_addr),
		.sp_addr(sp_addr),
		.cpu_rom_byte(cpu_rom_byte)
	);

	core_reset_gen core_reset_gen_inst (
		.CLOCK_48(CLOCK_48),
		.rst(rst),
		.ioctl_download(ioctl_download),
		.status_reset(status_reset),
		.menu_button(menu_button),
		.core_reset(core_reset),
		.rom_loaded()               // only the registered reset leaves the block
	);

	key_decoder key_decoder_inst (
		.CLOCK_48(CLOCK_48),
		.rst(rst),
		.key_strobe(key_strobe),
		.key_pressed(key_pressed),
		.key_code(key_code),
		.btn_up(btn_up),
		.btn_down(btn_down),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.btn_coin(btn_coin),
		.btn_start1(btn_start1),
		.btn_start2(btn_start2),
		.btn_fire1(btn_fire1),
		.btn_fire2(btn_fire2)
	);

	control_mapper control_mapper_inst (
		.btn_up(btn_up),
		.btn_down(btn_down),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.btn_coin(btn_coin),
		.btn_start1(btn_start1),
		.btn_start2(btn_start2),
		.btn_fire1(btn_fire1),
		.btn_fire2(btn_fire2),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.status_rotate(status_rotate),
		.status_service(status_service),
		.ctr1(ctr1),
		.ctr2(ctr2)
	);

endmodule

/* pkwars_host_tb.sv */
module pkwars_host_tb;

	localparam logic [24:0] GFX_BASE = 25'h10000;
	localparam int MAX_ROWS = 80;

	// row kinds
	localparam int K_DOWNLOAD = 0;
	localparam int K_END      = 1;
	localparam int K_KEY      = 2;
	localparam int K_OPTS     = 3;
	localparam int K_READ     = 4;

	logic        CLOCK_48 = 1'b0;
	logic        rst;
	logic        led;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        port_we;
	logic        port1_req;
	logic [22:0] port1_a;
	logic [1:0]  port1_ds;
	logic [15:0] port1_d;
	logic        port2_req;
	logic [22:0] port2_a;
	logic [1:0]  port2_ds;
	logic [15:0] port2_d;
	logic [15:0] cpu1_addr;
	logic [15:0] sp_addr;
	logic [15:0] cpu1_q;
	logic [15:0] cpu_rom_addr;
	logic [13:0] gfx_rom_addr;
	logic [7:0]  cpu_rom_byte;
	logic        core_reset;
	logic [7:0]  ctr1;
	logic [7:0]  ctr2;
	logic        status_reset;
	logic        status_rotate;
	logic        status_service;
	logic        menu_button;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;

	// stimulus table, one column per array
	logic [2:0]  row_kind [0:MAX_ROWS-1];
	logic [31:0] row_arg  [0:MAX_ROWS-1];
	logic [15:0] row_data [0:MAX_ROWS-1];
	logic        row_flag [0:MAX_ROWS-1];
	logic [31:0] row_exp1 [0:MAX_ROWS-1];
	logic [31:0] row_exp2 [0:MAX_ROWS-1];
	int          n_rows;

	// reference state while the table is built
	logic [7:0]  key_list [0:8];  // up down left right coin start1 start2 fire1 fire2
	logic [8:0]  m_btn;
	logic [7:0]  m_joy0;
	logic [7:0]  m_joy1;
	logic        m_rot;
	logic        m_svc;
	logic [31:0] rng;
	logic        exp_req;         // expected level of both requests

	always #10 CLOCK_48 = ~CLOCK_48;

	pkwars_host #(
		.GFX_BASE(GFX_BASE)
	) pkwars_host_inst (
		.CLOCK_48(CLOCK_48), .rst(rst), .led(led),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.port_we(port_we), .port1_req(port1_req), .port1_a(port1_a),
		.port1_ds(port1_ds), .port1_d(port1_d), .port2_req(port2_req),
		.port2_a(port2_a), .port2_ds(port2_ds), .port2_d(port2_d),
		.cpu1_addr(cpu1_addr), .sp_addr(sp_addr), .cpu1_q(cpu1_q),
		.cpu_rom_addr(cpu_rom_addr), .gfx_rom_addr(gfx_rom_addr),
		.cpu_rom_byte(cpu_rom_byte), .core_reset(core_reset),
		.ctr1(ctr1), .ctr2(ctr2),
		.status_reset(status_reset), .status_rotate(status_rotate),
		.status_service(status_service), .menu_button(menu_button),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joystick_0(joystick_0), .joystick_1(joystick_1)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// {ds, word address} of the 16 bit image
	function automatic logic [24:0] port1_map(input logic [24:0] addr);
		return {addr[0], ~addr[0], addr[23:1]};
	endfunction

	// gfx words: offset bits 13..0 then bit 15, lane from bit 14
	function automatic logic [24:0] port2_map(input logic [24:0] addr);
		logic [24:0] b;
		b = addr - GFX_BASE;
		return {b[14], ~b[14], 8'd0, b[13:0], b[15]};
	endfunction

	function automatic int key_index(input logic [7:0] code);
		int k;
		for (k = 0; k < 9; k++)
			if (key_list[k] == code)
				return k;
		return -1;
	endfunction

	// {ctr1, ctr2} for the current reference state
	function automatic logic [15:0] ctrl_bytes();
		logic left;
		logic right;
		logic fire;
		logic [7:0] c1;
		logic [7:0] c2;
		if (m_rot) begin
			left  = m_btn[1] | m_joy0[2] | m_joy1[2];  // down
			right = m_btn[0] | m_joy0[3] | m_joy1[3];  // up
		end else begin
			left  = m_btn[2] | m_joy0[1] | m_joy1[1];
			right = m_btn[3] | m_joy0[0] | m_joy1[0];
		end
		fire = m_btn[7] | m_joy0[4] | m_joy1[4];
		c1 = ~{1'b0, m_svc, m_btn[5], 2'b00, fire, right, left};
		c2 = ~{~m_btn[4], 1'b0, m_btn[6], 2'b00, fire, right, left};
		return {c1, c2};
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		string line;
		if (got !== exp) begin
			line = $sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_run(line);
		end
	endtask

	task automatic add_row(input int kind, input logic [31:0] arg, input logic [15:0] data,
			input logic flag, input logic [31:0] e1, input logic [31:0] e2);
		row_kind[n_rows] = kind;
		row_arg[n_rows]  = arg;
		row_data[n_rows] = data;
		row_flag[n_rows] = flag;
		row_exp1[n_rows] = e1;
		row_exp2[n_rows] = e2;
		n_rows = n_rows + 1;
	endtask

	task automatic add_download(input logic [24:0] addr, input logic [7:0] d);
		add_row(K_DOWNLOAD, {7'd0, addr}, {8'd0, d}, 1'b0,
			{7'd0, port1_map(addr)}, {7'd0, port2_map(addr)});
	endtask

	task automatic add_key(input logic [7:0] code, input logic pressed);
		int idx;
		idx = key_index(code);
		if (idx >= 0)
			m_btn[idx] = pressed;  // unknown codes leave the model alone
		add_row(K_KEY, {24'd0, code}, 16'd0, pressed, {16'd0, ctrl_bytes()}, 32'd0);
	endtask

	task automatic add_opts(input logic [7:0] j0, input logic [7:0] j1,
			input logic rot, input logic svc);
		m_joy0 = j0;
		m_joy1 = j1;
		m_rot  = rot;
		m_svc  = svc;
		add_row(K_OPTS, {14'd0, rot, svc, j1, j0}, 16'd0, 1'b0, {16'd0, ctrl_bytes()}, 32'd0);
	endtask

	task automatic add_read(input logic [15:0] cpu, input logic [13:0] gfx,
			input logic [15:0] q);
		logic [15:0] lane;
		lane = q >> {cpu[0], 3'b000};  // odd address reads the high byte
		add_row(K_READ, {2'd0, gfx, cpu}, q, 1'b0, {1'b0, cpu[15:1], 2'b00, gfx},
			{24'd0, lane[7:0]});
	endtask

	task automatic build_table();
		int k;
		logic [31:0] r;
		key_list[0] = 8'h75;
		key_list[1] = 8'h72;
		key_list[2] = 8'h6b;
		key_list[3] = 8'h74;
		key_list[4] = 8'h76;
		key_list[5] = 8'h05;
		key_list[6] = 8'h06;
		key_list[7] = 8'h29;
		key_list[8] = 8'h11;
		// cpu side of the download
		add_download(25'h0, 8'h3c);
		add_download(25'h1, 8'hc3);
		for (k = 0; k < 6; k++) begin
			rng = xorshift(rng);
			add_download({9'd0, rng[15:0]}, rng[23:16]);
		end
		// gfx side, one byte per rom and lane first
		add_download(GFX_BASE, 8'h5a);
		add_download(GFX_BASE + 25'h4001, 8'ha5);
		add_download(GFX_BASE + 25'h8000, 8'h81);
		add_download(GFX_BASE + 25'hc003, 8'h18);
		for (k = 0; k < 6; k++) begin
			rng = xorshift(rng);
			add_download(GFX_BASE + {9'd0, rng[15:0]}, rng[31:24]);
		end
		add_row(K_END, 32'd0, 16'd0, 1'b0, 32'd0, 32'd0);
		for (k = 0; k < 9; k++) begin
			add_key(key_list[k], 1'b1);
			add_key(key_list[k], 1'b0);
		end
		add_key(8'h1c, 1'b1);          // not a game key
		add_opts(8'h01, 8'h00, 1'b0, 1'b0);
		add_opts(8'h00, 8'h02, 1'b0, 1'b0);
		add_opts(8'h10, 8'h10, 1'b0, 1'b0);
		add_opts(8'h04, 8'h08, 1'b1, 1'b0);  // rotated, down and up steer
		add_opts(8'h03, 8'h00, 1'b1, 1'b0);
		add_opts(8'h00, 8'h00, 1'b0, 1'b1);  // service
		add_key(8'h6b, 1'b1);
		add_opts(8'h01, 8'h00, 1'b0, 1'b0);  // left key plus right stick
		add_opts(8'h00, 8'h00, 1'b1, 1'b0);
		add_key(8'h72, 1'b1);
		add_key(8'h75, 1'b1);          // up steers right when rotated
		add_key(8'h6b, 1'b0);
		add_key(8'h72, 1'b0);
		add_key(8'h75, 1'b0);
		add_opts(8'h00, 8'h00, 1'b0, 1'b0);
		for (k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			add_opts(rng[7:0], rng[15:8], rng[16], rng[17]);
		end
		add_opts(8'h00, 8'h00, 1'b0, 1'b0);
		for (k = 0; k < 6; k++) begin
			rng = xorshift(rng);
			r = rng;
			rng = xorshift(rng);
			add_read(r[15:0], r[29:16], rng[15:0]);
		end
		add_read(16'h8001, 14'h3fff, 16'ha55a);  // odd byte
		add_read(16'h8000, 14'h0001, 16'ha55a);  // even byte
	endtask

	task automatic wait_reset_low(input string what);
		int n;
		n = 0;
		while (core_reset !== 1'b0 && n < 20) begin
			@(negedge CLOCK_48);
			n = n + 1;
		end
		if (core_reset !== 1'b0)
			fail_run({"timeout waiting for ", what});
	endtask

	task automatic apply_download(input int i);
		if (!ioctl_download) begin
			ioctl_download = 1'b1;
			@(negedge CLOCK_48);
		end
		ioctl_addr = row_arg[i][24:0];
		ioctl_dout = row_data[i][7:0];
		ioctl_wr   = 1'b1;
		exp_req    = ~exp_req;
		@(negedge CLOCK_48);
		check("port1_req", port1_req, exp_req);
		check("port2_req", port2_req, exp_req);
		check("port1_ds/port1_a", {port1_ds, port1_a}, row_exp1[i]);
		check("port1_d", port1_d, {row_data[i][7:0], row_data[i][7:0]});
		check("port2_ds/port2_a", {port2_ds, port2_a}, row_exp2[i]);
		check("port2_d", port2_d, {row_data[i][7:0], row_data[i][7:0]});
		check("port_we", port_we, 1'b1);
		check("led", led, 1'b0);
		check("cpu1_addr", cpu1_addr, 16'hffff);
		check("sp_addr", sp_addr, 16'hffff);
		check("core_reset", core_reset, 1'b1);
		@(negedge CLOCK_48);   // strobe still high, no second toggle
		check("port1_req", port1_req, exp_req);
		ioctl_wr = 1'b0;
		@(negedge CLOCK_48);
		check("port2_req", port2_req, exp_req);
	endtask

	task automatic apply_end();
		ioctl_download = 1'b0;
		wait_reset_low("core reset release after the download");
		check("led", led, 1'b1);
		status_reset = 1'b1;
		@(negedge CLOCK_48);
		check("core_reset", core_reset, 1'b1);
		status_reset = 1'b0;
		wait_reset_low("core reset release after status reset");
		menu_button = 1'b1;
		@(negedge CLOCK_48);
		check("core_reset", core_reset, 1'b1);
		menu_button = 1'b0;
		wait_reset_low("core reset release after menu button");
	endtask

	task automatic apply_key(input int i);
		key_code    = row_arg[i][7:0];
		key_pressed = row_flag[i];
		key_strobe  = 1'b1;
		@(negedge CLOCK_48);
		key_strobe = 1'b0;
		check("ctr1", ctr1, row_exp1[i][15:8]);
		check("ctr2", ctr2, row_exp1[i][7:0]);
	endtask

	task automatic apply_opts(input int i);
		joystick_0     = row_arg[i][7:0];
		joystick_1     = row_arg[i][15:8];
		status_service = row_arg[i][16];
		status_rotate  = row_arg[i][17];
		#1;                    // combinational, same cycle
		check("ctr1", ctr1, row_exp1[i][15:8]);
		check("ctr2", ctr2, row_exp1[i][7:0]);
		@(negedge CLOCK_48);
	endtask

	task automatic apply_read(input int i);
		cpu_rom_addr = row_arg[i][15:0];
		gfx_rom_addr = row_arg[i][29:16];
		cpu1_q       = row_data[i];
		#1;
		check("cpu1_addr", cpu1_addr, row_exp1[i][31:16]);
		check("sp_addr", sp_addr, row_exp1[i][15:0]);
		check("cpu_rom_byte", cpu_rom_byte, row_exp2[i][7:0]);
		@(negedge CLOCK_48);
	endtask

	initial begin
		int i;
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cpu1_q         = '0;
		cpu_rom_addr   = '0;
		gfx_rom_addr   = '0;
		status_reset   = 1'b0;
		status_rotate  = 1'b0;
		status_service = 1'b0;
		menu_button    = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		m_btn   = '0;
		m_joy0  = '0;
		m_joy1  = '0;
		m_rot   = 1'b0;
		m_svc   = 1'b0;
		rng     = 32'h0c76_44aa;
		exp_req = 1'b0;
		n_rows  = 0;
		build_table();
		repeat (5) @(negedge CLOCK_48);
		rst = 1'b0;
		check("core_reset", core_reset, 1'b1);
		check("port1_req", port1_req, 1'b0);
		check("port2_req", port2_req, 1'b0);
		check("ctr1", ctr1, 8'hff);
		check("ctr2", ctr2, 8'h7f);   // coin released reads as 0
		for (i = 0; i < n_rows; i++) begin
			case (row_kind[i])
				K_DOWNLOAD: apply_download(i);
				K_END:      apply_end();
				K_KEY:      apply_key(i);
				K_OPTS:     apply_opts(i);
				K_READ:     apply_read(i);
				default:    fail_run("unknown row kind in the stimulus table");
			endcase
		end
		$display("All tests passed");
		$finish;
	end

endmodule

/* pkwars_pkg.sv */
package pkwars_pkg;

	// loader side
	typedef logic [7:0]  byte_t;         // ioctl data, ps/2 key codes
	typedef logic [24:0] ioctl_addr_t;   // download byte address

	// sdram side
	typedef logic [22:0] sdram_waddr_t;  // write port word address
	typedef logic [15:0] sdram_raddr_t;  // cpu and sprite read ports
	typedef logic [15:0] word16_t;       // sdram data word

	// core side
	typedef logic [15:0] cpu_addr_t;     // cpu rom byte address
	typedef logic [13:0] gfx_addr_t;     // gfx rom word address
	typedef logic [7:0]  ctrl_byte_t;    // active low control byte

	// joystick bits from the firmware
	// 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [7:0]  joy_t;

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// ps/2 set 2 make codes
	localparam byte_t KEY_UP     = 8'h75;
	localparam byte_t KEY_DOWN   = 8'h72;
	localparam byte_t KEY_LEFT   = 8'h6b;
	localparam byte_t KEY_RIGHT  = 8'h74;
	localparam byte_t KEY_COIN   = 8'h76; // esc
	localparam byte_t KEY_START1 = 8'h05; // f1
	localparam byte_t KEY_START2 = 8'h06; // f2
	localparam byte_t KEY_FIRE2  = 8'h11; // alt
	localparam byte_t KEY_FIRE1  = 8'h29; // space

	// download layout
	// 0000-ffff   cpu roms, 16 bit word image
	// 10000-1ffff four gfx roms, packed to 32 bit words
	localparam ioctl_addr_t GFX_BASE_DEFAULT = 25'h10000;

	// read address while the loader owns the sdram
	localparam sdram_raddr_t RADDR_IDLE = 16'hffff;

endpackage

/* rom_port_ctrl.sv */
module rom_port_ctrl
	import pkwars_pkg::*;
#(
	parameter ioctl_addr_t GFX_BASE = GFX_BASE_DEFAULT
) (
	input  logic         CLOCK_48,
	input  logic         rst,

	// loader
	input  logic         ioctl_download,
	input  logic         ioctl_wr,
	input  ioctl_addr_t  ioctl_addr,
	input  byte_t        ioctl_dout,

	// core rom addresses
	input  cpu_addr_t    cpu_rom_addr,
	input  gfx_addr_t    gfx_rom_addr,
	input  word16_t      cpu1_q,

	// sdram write ports
	output logic         port_we,
	output logic         port1_req,
	output sdram_waddr_t port1_a,
	output logic [1:0]   port1_ds,
	output word16_t      port1_d,
	output logic         port2_req,
	output sdram_waddr_t port2_a,
	output logic [1:0]   port2_ds,
	output word16_t      port2_d,

	// sdram read ports
	output sdram_raddr_t cpu1_addr,
	output sdram_raddr_t sp_addr,
	output byte_t        cpu_rom_byte
);

	logic        ioctl_wr_last;  // registered write strobe
	logic        wr_rise;
	ioctl_addr_t gfx_offset;     // byte offset into the gfx area

	assign wr_rise = ioctl_wr & ~ioctl_wr_last & ioctl_download;

	// toggle requests, the controller acts on the change
	always_ff @(posedge CLOCK_48) begin
		if (rst) begin
			ioctl_wr_last <= 1'b0;
			port1_req     <= 1'b0;
			port2_req     <= 1'b0;
		end else begin
			ioctl_wr_last <= ioctl_wr;
			if (wr_rise) begin
				port1_req <= ~port1_req;
				port2_req <= ~port2_req;
			end
		end
	end

	assign port_we = ioctl_download;

	// port 1: plain 16 bit image of the download
	assign port1_a  = ioctl_addr[23:1];
	assign port1_ds = {ioctl_addr[0], ~ioctl_addr[0]};
	assign port1_d  = {ioctl_dout, ioctl_dout};

	// port 2: four 16k gfx roms merged into 32 bit words
	// bit 15 picks the word half, bit 14 the byte lane
	assign gfx_offset = ioctl_addr - GFX_BASE;
	assign port2_a    = {8'd0, gfx_offset[13:0], gfx_offset[15]};
	assign port2_ds   = {gfx_offset[14], ~gfx_offset[14]};
	assign port2_d    = {ioctl_dout, ioctl_dout};

	// park the read ports while loading
	always_comb begin
		if (ioctl_download) begin
			cpu1_addr = RADDR_IDLE;
			sp_addr   = RADDR_IDLE;
		end else begin
			cpu1_addr = {1'b0, cpu_rom_addr[15:1]};
			sp_addr   = {2'b00, gfx_rom_addr};
		end
	end

	assign cpu_rom_byte = cpu_rom_addr[0] ? cpu1_q[15:8] : cpu1_q[7:0];

	// no sdram write may be requested outside a download
	req_only_in_download: assert property (
		@(posedge CLOCK_48) disable iff (rst)
		(port1_req != $past(port1_req)) |-> $past(ioctl_download)
	);

endmodule
